/* dv/fir_checker.sv */
`timescale 1ns/1ns

module fir_checker (
    input  logic                 axis_clk,
    input  logic                 axis_rst_n,
    input  logic                 ss_tready,
    input  logic                 sm_tvalid,
    input  logic                 sm_tready,
    input  fir_dsp_pkg::sample_t sm_tdata,
    input  logic                 sm_tlast,
    input  logic                 rvalid
);

    int fail_count = 0;

    // Stalled output holds its word
    a_sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
    else begin
        $error("sm stream changed while stalled");
        fail_count++;
    end

    a_one_at_a_time: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !(ss_tready && sm_tvalid))
    else begin
        $error("ss_tready high while an output is pending");
        fail_count++;
    end

    a_rvalid_pulse: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid |=> !rvalid)
    else begin
        $error("rvalid held for two cycles");
        fail_count++;
    end

endmodule

bind fir_top fir_checker checker0 (.*);

/* dv/fir_tb.sv */
`timescale 1ns/1ns

`include "fir_consts.svh"

module fir_tb;

    localparam int FILTER_LEN = 20;
    localparam int STALL_LEN = 20;
    localparam int CTRL_LEN = 8;
    localparam int RESTART_LEN = 5;
    localparam int TOTAL_SAMPLES = FILTER_LEN + STALL_LEN + CTRL_LEN + RESTART_LEN;
    localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 40 + 2000;

    logic                    axis_clk;
    logic                    axis_rst_n;
    logic                    awvalid;
    fir_axil_pkg::bus_addr_t awaddr;
    logic                    awready;
    logic                    wvalid;
    fir_axil_pkg::bus_data_t wdata;
    logic                    wready;
    logic                    arvalid;
    fir_axil_pkg::bus_addr_t araddr;
    logic                    arready;
    logic                    rready;
    logic                    rvalid;
    fir_axil_pkg::bus_data_t rdata;
    logic                    ss_tvalid;
    fir_dsp_pkg::sample_t    ss_tdata;
    logic                    ss_tlast;
    logic                    ss_tready;
    logic                    sm_tready;
    logic                    sm_tvalid;
    fir_dsp_pkg::sample_t    sm_tdata;
    logic                    sm_tlast;

    int                      errors;
    fir_dsp_pkg::coef_t      taps [`FIR_NUM_TAPS];
    fir_dsp_pkg::sample_t    blk_x [32];
    fir_dsp_pkg::sample_t    first_in;
    fir_dsp_pkg::sample_t    first_out;

    fir_top dut0 (.*);

    always #4 axis_clk = ~axis_clk;

    task automatic check_word(input string name, input fir_axil_pkg::bus_data_t exp,
                              input fir_axil_pkg::bus_data_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_sample(input string name, input fir_dsp_pkg::sample_t exp,
                                input fir_dsp_pkg::sample_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    function automatic fir_axil_pkg::bus_addr_t tap_address(input int k);
        return `FIR_TAP_BASE + 4 * k;
    endfunction

    // Reference convolution with samples before the block taken as zero
    function automatic fir_dsp_pkg::sample_t golden(input int n);
        fir_dsp_pkg::sample_t acc;
        acc = '0;
        for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
            if (n - k >= 0) begin
                acc = acc + taps[k] * blk_x[n - k];
            end
        end
        return acc;
    endfunction

    // Handshakes are sampled 1 ns after the falling edge
    task automatic axil_write(input fir_axil_pkg::bus_addr_t addr,
                              input fir_axil_pkg::bus_data_t data);
        @(negedge axis_clk);
        awvalid = 1'b1;
        awaddr  = addr;
        #1;
        while (!awready) begin
            @(negedge axis_clk);
            #1;
        end
        @(negedge axis_clk);
        awvalid = 1'b0;
        wvalid  = 1'b1;
        wdata   = data;
        #1;
        while (!wready) begin
            @(negedge axis_clk);
            #1;
        end
        @(negedge axis_clk);
        wvalid = 1'b0;
    endtask

    task automatic axil_read(input fir_axil_pkg::bus_addr_t addr,
                             output fir_axil_pkg::bus_data_t data);
        @(negedge axis_clk);
        arvalid = 1'b1;
        araddr  = addr;
        #1;
        while (!arready) begin
            @(negedge axis_clk);
            #1;
        end
        @(negedge axis_clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        #1;
        while (!rvalid) begin
            @(negedge axis_clk);
            #1;
        end
        data = rdata;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    task automatic send_sample(input fir_dsp_pkg::sample_t data, input logic last);
        @(negedge axis_clk);
        ss_tvalid = 1'b1;
        ss_tdata  = data;
        ss_tlast  = last;
        #1;
        while (!ss_tready) begin
            @(negedge axis_clk);
            #1;
        end
        @(negedge axis_clk);
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    task automatic recv_result(input int stall, output fir_dsp_pkg::sample_t data,
                               output logic last);
        @(negedge axis_clk);
        #1;
        while (!sm_tvalid) begin
            @(negedge axis_clk);
            #1;
        end
        repeat (stall) @(negedge axis_clk);
        @(negedge axis_clk);
        sm_tready = 1'b1;
        #1;
        data = sm_tdata;
        last = sm_tlast;
        @(negedge axis_clk);
        sm_tready = 1'b0;
    endtask

    task automatic verify_taps();
        fir_axil_pkg::bus_data_t rd;
        for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
            axil_read(tap_address(k), rd);
            check_word("rdata tap", taps[k], rd);
        end
    endtask

    // Bus traffic while the engine owns the taps
    task automatic probe_busy();
        fir_axil_pkg::bus_data_t rd;
        axil_read(`FIR_CTRL_ADDR, rd);
        check_word("rdata ctrl busy", 32'h0, rd);
        axil_read(tap_address(3), rd);
        check_word("rdata tap busy", 32'hffff_ffff, rd);
        axil_write(tap_address(3), ~taps[3]);
    endtask

    task automatic run_block(input int n, input int max_stall, input bit probe);
        fir_dsp_pkg::sample_t    got;
        logic                    got_last;
        fir_axil_pkg::bus_data_t rd;
        int                      stall;
        axil_write(`FIR_CTRL_ADDR, 32'h1);
        blk_x[0] = fir_dsp_pkg::sample_t'($urandom);
        send_sample(blk_x[0], n == 1);
        for (int i = 0; i < n; i++) begin
            if (probe && i == 1) begin
                probe_busy();
            end
            stall = (max_stall > 0) ? $urandom_range(max_stall, 0) : 0;
            if (i < n - 1) begin
                // Next sample is offered while this output is still pending
                blk_x[i + 1] = fir_dsp_pkg::sample_t'($urandom);
                fork
                    send_sample(blk_x[i + 1], i + 1 == n - 1);
                    recv_result(stall, got, got_last);
                join
            end else begin
                recv_result(stall, got, got_last);
            end
            check_sample("sm_tdata", golden(i), got);
            check_last("sm_tlast", i == n - 1, got_last);
            if (i == 0) begin
                first_in  = blk_x[0];
                first_out = got;
            end
        end
        axil_read(`FIR_CTRL_ADDR, rd);
        check_word("rdata ctrl done", 32'h6, rd);
        axil_read(`FIR_CTRL_ADDR, rd);
        check_word("rdata ctrl cleared", 32'h4, rd);
    endtask

    task automatic reset_test();
        fir_axil_pkg::bus_data_t rd;
        for (int i = 0; i < 8; i++) begin
            @(negedge axis_clk);
            #1;
            if (sm_tvalid || sm_tlast || ss_tready || awready || wready || arready ||
                rvalid) begin
                errors++;
                $display("Handshake output went high right after reset");
            end
        end
        axil_read(`FIR_CTRL_ADDR, rd);
        check_word("rdata ctrl reset", 32'h4, rd);
    endtask

    task automatic tap_access_test();
        for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
            taps[k] = fir_dsp_pkg::coef_t'($urandom);
            axil_write(tap_address(k), taps[k]);
        end
        verify_taps();
    endtask

    task automatic filter_test();
        run_block(FILTER_LEN, 0, 1'b0);
    endtask

    task automatic backpressure_test();
        run_block(STALL_LEN, 6, 1'b0);
    endtask

    task automatic control_test();
        run_block(CTRL_LEN, 2, 1'b1);
        verify_taps();
    endtask

    task automatic restart_test();
        run_block(RESTART_LEN, 0, 1'b0);
        check_sample("sm_tdata first", taps[0] * first_in, first_out);
    endtask

    initial begin
        void'($urandom(41508));
        errors     = 0;
        axis_clk   = 1'b0;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b0;
        repeat (3) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;

        reset_test();
        tap_access_test();
        filter_test();
        backpressure_test();
        control_test();
        restart_test();

        errors += dut0.checker0.fail_count;
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge axis_clk);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* include/fir_consts.svh */
`ifndef FIR_CONSTS_SVH
`define FIR_CONSTS_SVH

// Filter geometry
`define FIR_NUM_TAPS 11
`define FIR_DATA_W 32

// Register bus
`define FIR_ADDR_W 12

// Register map
`define FIR_CTRL_ADDR 12'h000
`define FIR_TAP_BASE 12'h040

`endif

/* rtl/fir_axil_pkg.sv */
package fir_axil_pkg;

    `include "fir_consts.svh"

    typedef logic [`FIR_ADDR_W-1:0] bus_addr_t;
    typedef logic [`FIR_DATA_W-1:0] bus_data_t;

    // Control word, bit 2 down to bit 0
    typedef struct packed {
        logic idle;
        logic done;
        logic start;
    } ap_ctrl_t;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_WDATA,
        BUS_RWAIT,
        BUS_RDATA
    } bus_state_t;

endpackage

/* rtl/fir_axil_regs.sv */
`timescale 1ns/1ns

`include "fir_consts.svh"

module fir_axil_regs (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    awvalid,
    input  fir_axil_pkg::bus_addr_t awaddr,
    output logic                    awready,
    input  logic                    wvalid,
    input  fir_axil_pkg::bus_data_t wdata,
    output logic                    wready,
    input  logic                    arvalid,
    input  fir_axil_pkg::bus_addr_t araddr,
    output logic                    arready,
    input  logic                    rready,
    output logic                    rvalid,
    output fir_axil_pkg::bus_data_t rdata,
    output logic                    run,
    input  logic                    busy,
    input  logic                    first_take,
    input  logic                    block_end,
    input  fir_dsp_pkg::tap_idx_t   tap_rd_idx,
    output fir_dsp_pkg::tap_idx_t   tap_addr,
    output logic                    tap_we,
    output fir_dsp_pkg::coef_t      tap_wdata,
    input  fir_dsp_pkg::coef_t      tap_rdata,
    output fir_dsp_pkg::coef_t      tap_coef
);

    fir_axil_pkg::bus_state_t bus_state;
    fir_axil_pkg::bus_addr_t  addr_q;
    fir_axil_pkg::bus_addr_t  tap_off;
    fir_axil_pkg::ap_ctrl_t   ctrl;
    fir_dsp_pkg::tap_idx_t    bus_idx;
    logic                     rd_turn;
    logic                     locked;
    logic                     lock_q;
    logic                     is_ctrl;
    logic                     is_tap;
    logic                     wr_fire;

    // Read wins only when the last grant went to a write
    assign awready = (bus_state == fir_axil_pkg::BUS_IDLE) & awvalid & ~(arvalid & rd_turn);
    assign arready = (bus_state == fir_axil_pkg::BUS_IDLE) & arvalid & ~(awvalid & ~rd_turn);
    assign wready  = (bus_state == fir_axil_pkg::BUS_WDATA);
    assign rvalid  = (bus_state == fir_axil_pkg::BUS_RDATA);
    assign wr_fire = wready & wvalid;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            bus_state <= fir_axil_pkg::BUS_IDLE;
            addr_q    <= '0;
            rd_turn   <= 1'b0;
        end else begin
            case (bus_state)
                fir_axil_pkg::BUS_IDLE: begin
                    if (awready) begin
                        bus_state <= fir_axil_pkg::BUS_WDATA;
                        addr_q    <= awaddr;
                        rd_turn   <= 1'b1;
                    end else if (arready) begin
                        bus_state <= fir_axil_pkg::BUS_RWAIT;
                        addr_q    <= araddr;
                        rd_turn   <= 1'b0;
                    end
                end
                fir_axil_pkg::BUS_WDATA: begin
                    if (wvalid) begin
                        bus_state <= fir_axil_pkg::BUS_IDLE;
                    end
                end
                fir_axil_pkg::BUS_RWAIT: begin
                    if (rready) begin
                        bus_state <= fir_axil_pkg::BUS_RDATA;
                    end
                end
                default: begin
                    bus_state <= fir_axil_pkg::BUS_IDLE;
                end
            endcase
        end
    end

    // Address decode
    assign is_ctrl = (addr_q == `FIR_CTRL_ADDR);
    assign is_tap  = (addr_q >= `FIR_TAP_BASE) && (addr_q < `FIR_TAP_BASE + 4 * `FIR_NUM_TAPS);
    assign tap_off = addr_q - `FIR_TAP_BASE;
    assign bus_idx = is_tap ? tap_off[$bits(fir_dsp_pkg::tap_idx_t)+1:2] : '0;

    // Engine owns the tap memory from start until the block ends
    assign locked    = run | busy;
    assign tap_addr  = locked ? tap_rd_idx : bus_idx;
    assign tap_we    = wr_fire & is_tap & ~locked;
    assign tap_wdata = wdata;
    assign tap_coef  = tap_rdata;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ctrl   <= '{idle: 1'b1, done: 1'b0, start: 1'b0};
            lock_q <= 1'b0;
        end else begin
            lock_q <= locked;
            if (wr_fire && is_ctrl && ctrl.idle && wdata[0]) begin
                ctrl.start <= 1'b1;
                ctrl.idle  <= 1'b0;
            end
            if (first_take) begin
                ctrl.start <= 1'b0;
            end
            // done is read-to-clear
            if (rvalid && is_ctrl) begin
                ctrl.done <= 1'b0;
            end
            if (block_end) begin
                ctrl.done <= 1'b1;
                ctrl.idle <= 1'b1;
            end
        end
    end

    assign run = ctrl.start;

    always_comb begin
        rdata = '0;
        if (rvalid) begin
            if (is_ctrl) begin
                rdata[$bits(ctrl)-1:0] = ctrl;
            end else if (is_tap) begin
                rdata = (locked | lock_q) ? '1 : tap_rdata;
            end
        end
    end

endmodule

/* rtl/fir_dsp_pkg.sv */
package fir_dsp_pkg;

    `include "fir_consts.svh"

    typedef logic signed [`FIR_DATA_W-1:0] sample_t;
    typedef logic signed [`FIR_DATA_W-1:0] coef_t;

    // Wide enough for one step past the last tap
    typedef logic [3:0] tap_idx_t;

    typedef enum logic [1:0] {
        ENG_CLEAR,
        ENG_WAIT,
        ENG_TAP,
        ENG_OUT
    } eng_state_t;

endpackage

/* rtl/fir_engine.sv */
`timescale 1ns/1ns

`include "fir_consts.svh"

module fir_engine (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  ss_tvalid,
    input  fir_dsp_pkg::sample_t  ss_tdata,
    input  logic                  ss_tlast,
    output logic                  ss_tready,
    input  logic                  sm_tready,
    output logic                  sm_tvalid,
    output fir_dsp_pkg::sample_t  sm_tdata,
    output logic                  sm_tlast,
    input  logic                  run,
    output logic                  busy,
    output logic                  first_take,
    output logic                  block_end,
    output fir_dsp_pkg::tap_idx_t tap_rd_idx,
    input  fir_dsp_pkg::coef_t    tap_coef,
    output fir_dsp_pkg::tap_idx_t dl_addr,
    output logic                  dl_we,
    output fir_dsp_pkg::sample_t  dl_wdata,
    input  fir_dsp_pkg::sample_t  dl_rdata
);

    fir_dsp_pkg::eng_state_t state;
    fir_dsp_pkg::tap_idx_t   idx;
    fir_dsp_pkg::sample_t    smp;
    fir_dsp_pkg::sample_t    x_k;
    fir_dsp_pkg::sample_t    x_d;
    fir_dsp_pkg::sample_t    acc;
    logic                    last_q;
    logic                    take;
    logic                    in_range;

    // One sample per visit to the wait state
    assign ss_tready = (state == fir_dsp_pkg::ENG_WAIT) & busy & ss_tvalid;
    assign take      = ss_tvalid & ss_tready;

    // Start bit is still set while the first sample goes in
    assign first_take = take & run;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state  <= fir_dsp_pkg::ENG_WAIT;
            idx    <= '0;
            busy   <= 1'b0;
            last_q <= 1'b0;
        end else begin
            case (state)
                fir_dsp_pkg::ENG_WAIT: begin
                    if (!busy && run) begin
                        state <= fir_dsp_pkg::ENG_CLEAR;
                        idx   <= '0;
                        busy  <= 1'b1;
                    end else if (take) begin
                        state  <= fir_dsp_pkg::ENG_TAP;
                        idx    <= '0;
                        last_q <= ss_tlast;
                    end
                end
                fir_dsp_pkg::ENG_CLEAR: begin
                    if (idx == `FIR_NUM_TAPS - 1) begin
                        state <= fir_dsp_pkg::ENG_WAIT;
                    end
                    idx <= idx + 1'b1;
                end
                fir_dsp_pkg::ENG_TAP: begin
                    // One extra step to fold in the last product
                    if (idx == `FIR_NUM_TAPS) begin
                        state <= fir_dsp_pkg::ENG_OUT;
                    end
                    idx <= idx + 1'b1;
                end
                default: begin
                    if (sm_tready) begin
                        state <= fir_dsp_pkg::ENG_WAIT;
                        if (last_q) begin
                            busy <= 1'b0;
                        end
                    end
                end
            endcase
        end
    end

    assign in_range = (idx < `FIR_NUM_TAPS);

    // Step k reads tap k and the sample at entry k-1, which arrives on dl_rdata
    assign x_k        = (idx == '0) ? smp : dl_rdata;
    assign tap_rd_idx = in_range ? idx : '0;
    assign dl_addr    = in_range ? idx : '0;
    assign dl_we      = (state == fir_dsp_pkg::ENG_CLEAR) |
                        ((state == fir_dsp_pkg::ENG_TAP) & in_range);
    assign dl_wdata   = (state == fir_dsp_pkg::ENG_CLEAR) ? '0 : x_k;

    always_ff @(posedge axis_clk) begin
        if (take) begin
            smp <= ss_tdata;
            acc <= '0;
        end
        if (state == fir_dsp_pkg::ENG_TAP) begin
            x_d <= x_k;
            // Tap coefficient lags its index by one cycle
            if (idx != '0) begin
                acc <= acc + tap_coef * x_d;
            end
        end
    end

    assign sm_tvalid = (state == fir_dsp_pkg::ENG_OUT);
    assign sm_tdata  = acc;
    assign sm_tlast  = sm_tvalid & last_q;
    assign block_end = sm_tvalid & sm_tready & sm_tlast;

endmodule

/* rtl/fir_ram.sv */
`timescale 1ns/1ns

module fir_ram #(
    parameter type word_t = fir_dsp_pkg::sample_t,
    parameter int DEPTH = 16
) (
    input  logic                   axis_clk,
    input  fir_dsp_pkg::tap_idx_t  addr,
    input  logic                   we,
    input  word_t                  wdata,
    output word_t                  rdata
);

    word_t mem [DEPTH];

    // Read returns the old word when the same address is written
    always_ff @(posedge axis_clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* rtl/fir_top.sv */
`timescale 1ns/1ns

`include "fir_consts.svh"

module fir_top (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    awvalid,
    input  fir_axil_pkg::bus_addr_t awaddr,
    output logic                    awready,
    input  logic                    wvalid,
    input  fir_axil_pkg::bus_data_t wdata,
    output logic                    wready,
    input  logic                    arvalid,
    input  fir_axil_pkg::bus_addr_t araddr,
    output logic                    arready,
    input  logic                    rready,
    output logic                    rvalid,
    output fir_axil_pkg::bus_data_t rdata,
    input  logic                    ss_tvalid,
    input  fir_dsp_pkg::sample_t    ss_tdata,
    input  logic                    ss_tlast,
    output logic                    ss_tready,
    input  logic                    sm_tready,
    output logic                    sm_tvalid,
    output fir_dsp_pkg::sample_t    sm_tdata,
    output logic                    sm_tlast
);

    logic                  run;
    logic                  busy;
    logic                  first_take;
    logic                  block_end;
    fir_dsp_pkg::tap_idx_t tap_rd_idx;
    fir_dsp_pkg::tap_idx_t tap_addr;
    logic                  tap_we;
    fir_dsp_pkg::coef_t    tap_wdata;
    fir_dsp_pkg::coef_t    tap_rdata;
    fir_dsp_pkg::coef_t    tap_coef;
    fir_dsp_pkg::tap_idx_t dl_addr;
    logic                  dl_we;
    fir_dsp_pkg::sample_t  dl_wdata;
    fir_dsp_pkg::sample_t  dl_rdata;

    fir_axil_regs regs0 (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rready     (rready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .run        (run),
        .busy       (busy),
        .first_take (first_take),
        .block_end  (block_end),
        .tap_rd_idx (tap_rd_idx),
        .tap_addr   (tap_addr),
        .tap_we     (tap_we),
        .tap_wdata  (tap_wdata),
        .tap_rdata  (tap_rdata),
        .tap_coef   (tap_coef)
    );

    fir_engine engine0 (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .run        (run),
        .busy       (busy),
        .first_take (first_take),
        .block_end  (block_end),
        .tap_rd_idx (tap_rd_idx),
        .tap_coef   (tap_coef),
        .dl_addr    (dl_addr),
        .dl_we      (dl_we),
        .dl_wdata   (dl_wdata),
        .dl_rdata   (dl_rdata)
    );

    fir_ram #(
        .word_t (fir_dsp_pkg::coef_t),
        .DEPTH  (`FIR_NUM_TAPS)
    ) tap_ram (
        .axis_clk (axis_clk),
        .addr     (tap_addr),
        .we       (tap_we),
        .wdata    (tap_wdata),
        .rdata    (tap_rdata)
    );

    fir_ram #(
        .word_t (fir_dsp_pkg::sample_t),
        .DEPTH  (`FIR_NUM_TAPS)
    ) delay_ram (
        .axis_clk (axis_clk),
        .addr     (dl_addr),
        .we       (dl_we),
        .wdata    (dl_wdata),
        .rdata    (dl_rdata)
    );

endmodule

/* sim.f */
+incdir+include
rtl/fir_axil_pkg.sv
rtl/fir_dsp_pkg.sv
rtl/fir_ram.sv
rtl/fir_axil_regs.sv
rtl/fir_engine.sv
rtl/fir_top.sv
dv/fir_checker.sv
dv/fir_tb.sv
